/* au_cluster.f */
src/au_pkg.sv
src/au_op_decode.sv
src/slice_regfile.sv
src/au_execute.sv
src/au_cluster_top.sv
dv/au_cluster_assertions.sv
dv/au_cluster_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the AU cluster testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f au_cluster.f --top-module au_cluster_tb -o au_cluster_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/au_cluster_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Simulation completed successfully"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1

/* dv/au_cluster_tb.sv */
// AU cluster testbench
// Issues one op per cycle to the slice whose turn it is, mirrors each
// slice's registers and flags in a reference model and checks the result bus
`timescale 1ns/1ps

module au_cluster_tb;

  import au_pkg::*;

  localparam int N_SLICES    = 4;
  localparam int N_RANDOM    = 240;
  localparam int N_FIXED     = 14;
  localparam int NUM_OPS     = 2 * N_SLICES + 4 + 4 * 16 * N_SLICES + N_RANDOM +
                               N_FIXED * N_SLICES;
  localparam int WATCHDOG_NS = (NUM_OPS + 20) * N_SLICES * 20;

  typedef struct packed {
    logic [31:0] cyc;
    logic        wb;
    logic [2:0]  slice;
    logic [3:0]  rc_sel;
    logic [31:0] data;
    logic [7:0]  flags;
  } expect_t;

  logic        CLK;
  logic        RST;
  logic        op_vld;
  au_op_t      op;
  logic [2:0]  slice;
  logic [7:0]  cur_flags;
  logic        rc_vld;
  logic [2:0]  rc_slice;
  logic [3:0]  rc_sel;
  logic [31:0] rc;

  logic [31:0] ref_regs [N_SLICES][16];
  logic [7:0]  ref_flags [N_SLICES];
  expect_t     exp_q [$];
  expect_t     head;
  logic [31:0] cyc;
  logic [31:0] lcg_state;
  logic        running;
  int          turn;
  int          exp_turn;
  logic [7:0]  exp_flags;
  int          errors;
  int          checks;

  au_cluster_top #(
    .N_SLICES (N_SLICES)
  ) au_cluster_top_inst (
    .CLK       (CLK),
    .RST       (RST),
    .op_vld    (op_vld),
    .op        (op),
    .slice     (slice),
    .cur_flags (cur_flags),
    .rc_vld    (rc_vld),
    .rc_slice  (rc_slice),
    .rc_sel    (rc_sel),
    .rc        (rc)
  );

  always #10 CLK = ~CLK;

  always @(posedge CLK or posedge RST)
  begin
    if (RST)
      cyc <= '0;
    else
      cyc <= cyc + 32'd1;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [14:0] enc_2r(input logic [3:0] cmd, input logic [3:0] rb,
                                         input logic [3:0] ra);
    return {3'b000, cmd, rb, ra};
  endfunction

  function automatic logic [14:0] enc_3r(input logic [2:0] cmd, input logic [2:0] rc_r,
                                         input logic [2:0] rb, input logic [2:0] ra);
    return {3'b001, cmd, rc_r, rb, ra};
  endfunction

  function automatic logic [14:0] enc_bit(input logic [2:0] cmd, input logic [4:0] bsel,
                                          input logic [3:0] rs);
    return {3'b010, cmd, bsel, rs};
  endfunction

  function automatic logic [14:0] enc_addi(input logic [3:0] rs, input logic [7:0] val);
    return {3'b011, val, rs};
  endfunction

  function automatic logic [14:0] enc_cmpi(input logic [3:0] rs, input logic [8:0] val);
    return {2'b10, val, rs};
  endfunction

  function automatic logic [14:0] enc_ldi(input logic [3:0] rs, input logic [8:0] val);
    return {2'b11, val, rs};
  endfunction

  // Expected writeback and flags from the instruction rules
  function automatic expect_t ref_model(input int s, input logic [14:0] w);
    expect_t            e;
    logic [3:0]         cmd;
    logic [3:0]         ra;
    logic [3:0]         rb;
    logic [4:0]         bsel;
    logic [31:0]        ua;
    logic [31:0]        ub;
    logic signed [63:0] a;
    logic signed [63:0] b;
    logic signed [63:0] r;
    e = '0;
    r = '0;
    if (w[14:13] == 2'b00)
    begin
      if (w[12])
      begin
        cmd      = {1'b0, w[11:9]};
        e.rc_sel = {1'b0, w[8:6]};
        rb       = {1'b0, w[5:3]};
        ra       = {1'b0, w[2:0]};
      end
      else
      begin
        cmd      = w[11:8];
        rb       = w[7:4];
        ra       = w[3:0];
        e.rc_sel = w[3:0];
      end
      ua = ref_regs[s][ra];
      ub = ref_regs[s][rb];
      a  = {{32{ua[31]}}, ua};
      b  = {{32{ub[31]}}, ub};
      // Logical results carry a zero guard bit
      case (cmd)
        4'h0:    r = 64'(ua | ub);
        4'h1:    r = 64'(ua & ub);
        4'h2:    r = 64'(ua ^ ub);
        4'h3:    r = a + b;
        4'h4:    r = a - b;
        4'h8:    r = b;
        4'h9:    r = ~b;
        4'hA:    r = -b;
        4'hB:    r = a - b;
        default: r = '0;
      endcase
      e.wb = (cmd != 4'hB);
    end
    else if (w[14:12] == 3'b010)
    begin
      cmd      = {1'b0, w[11:9]};
      bsel     = w[8:4];
      e.rc_sel = w[3:0];
      ua       = ref_regs[s][w[3:0]];
      a        = {{32{ua[31]}}, ua};
      case (cmd[2:0])
        3'd0:    r = 64'(ua | (32'd1 << bsel));
        3'd1:    r = 64'(ua & ~(32'd1 << bsel));
        3'd2:    r = 64'(ua & (32'd1 << bsel));
        3'd4:    r = 64'(ua) << bsel;
        3'd5:    r = 64'(ua >> bsel);
        3'd6:    r = a >>> bsel;
        3'd7:
        begin
          r = 64'(ua);
          for (int i = 0; i < 64; i++)
            if (i >= int'(bsel))
              r[i] = ua[bsel];
        end
        default: r = '0;
      endcase
      e.wb = (cmd[2:0] != 3'd2);
    end
    else
    begin
      e.rc_sel = w[3:0];
      ua       = ref_regs[s][w[3:0]];
      a        = {{32{ua[31]}}, ua};
      // 9-bit value for load and compare, 8-bit for add
      if (w[14])
        b = {{55{w[12]}}, w[12:4]};
      else
        b = {{56{w[11]}}, w[11:4]};
      case (w[14:13])
        2'b01:   r = a + b;
        2'b10:   r = a - b;
        default: r = b;
      endcase
      e.wb = (w[14:13] != 2'b10);
    end
    e.data  = r[31:0];
    e.flags = {5'd0, r[32] ^ r[31], r[31], (r[31:0] == 32'd0)};
    return e;
  endfunction

  function automatic logic [3:0] pick_tworeg(input int k);
    case (k)
      0:       return 4'h0;
      1:       return 4'h1;
      2:       return 4'h2;
      3:       return 4'h3;
      4:       return 4'h4;
      5:       return 4'h9;
      default: return 4'hA;
    endcase
  endfunction

  function automatic logic [2:0] pick_bitop(input int k);
    case (k)
      0:       return 3'd0;
      1:       return 3'd1;
      2:       return 3'd4;
      3:       return 3'd5;
      4:       return 3'd6;
      default: return 3'd7;
    endcase
  endfunction

  function automatic logic [14:0] random_op();
    logic [31:0] r;
    logic [14:0] w;
    r = lcg_next();
    case (r[31:30])
      2'd0:    w = enc_2r(pick_tworeg(int'(r[15:0] % 16'd7)), r[27:24], r[23:20]);
      2'd1:    w = enc_3r(3'(r[15:0] % 16'd5), r[26:24], r[22:20], r[18:16]);
      2'd2:    w = enc_bit(pick_bitop(int'(r[15:0] % 16'd6)), r[28:24], r[19:16]);
      default: w = enc_ldi(r[19:16], r[28:20]);
    endcase
    return w;
  endfunction

  // Boundary values, then compares and tests that leave the registers alone
  function automatic logic [14:0] fixed_op(input int i);
    case (i)
      0:       return enc_ldi(4'd1, 9'h1FF);
      1:       return enc_bit(3'd5, 5'd1, 4'd1);
      2:       return enc_2r(4'h8, 4'd1, 4'd2);
      3:       return enc_addi(4'd2, 8'd1);
      4:       return enc_ldi(4'd3, 9'd0);
      5:       return enc_3r(3'd4, 3'd4, 3'd2, 3'd3);
      6:       return enc_2r(4'hA, 4'd2, 4'd5);
      7:       return enc_2r(4'h3, 4'd1, 4'd1);
      8:       return enc_2r(4'hB, 4'd2, 4'd2);
      9:       return enc_bit(3'd2, 5'd31, 4'd2);
      10:      return enc_cmpi(4'd3, 9'd0);
      11:      return enc_cmpi(4'd1, 9'h1FF);
      12:      return enc_bit(3'd2, 5'd0, 4'd3);
      default: return enc_2r(4'h8, 4'd2, 4'd6);
    endcase
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAIL %0t ns: %s, got %08h expected %08h", $time, what, got, exp);
    end
  endtask

  // One cycle for the current slice, entered 2 ns after the rising edge
  task automatic step(input logic vld, input logic [14:0] word);
    expect_t e;
    exp_turn  = turn;
    exp_flags = ref_flags[turn];
    op_vld    = vld;
    op        = word;
    if (vld)
    begin
      e        = ref_model(turn, word);
      e.cyc    = cyc;
      e.slice  = 3'(turn);
      exp_q.push_back(e);
      if (e.wb)
        ref_regs[turn][e.rc_sel] = e.data;
      ref_flags[turn] = e.flags;
    end
    @(posedge CLK);
    #2;
    turn = (turn + 1) % N_SLICES;
  endtask

  always @(negedge CLK)
  begin
    if (running)
    begin
      check(32'(slice), 32'(exp_turn), "slice counter");
      check(32'(cur_flags), 32'(exp_flags), "cur_flags of current slice");
      if ((exp_q.size() > 0) && (exp_q[0].cyc + 32'd2 == cyc))
      begin
        head = exp_q.pop_front();
        check(32'(rc_vld), 32'(head.wb), "rc_vld two cycles after issue");
        if (head.wb)
        begin
          check(32'(rc_slice), 32'(head.slice), "rc_slice");
          check(32'(rc_sel), 32'(head.rc_sel), "rc_sel");
          check(rc, head.data, "rc data");
        end
      end
      else
        check(32'(rc_vld), 32'd0, "rc_vld without an issued op");
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog timeout after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

  initial
  begin
    CLK       = 1'b0;
    RST       = 1'b1;
    op_vld    = 1'b0;
    op        = '0;
    running   = 1'b0;
    turn      = 0;
    exp_turn  = 0;
    exp_flags = '0;
    errors    = 0;
    checks    = 0;
    lcg_state = 32'd57468;
    for (int s = 0; s < N_SLICES; s++)
    begin
      ref_flags[s] = '0;
      for (int j = 0; j < 16; j++)
        ref_regs[s][j] = '0;
    end
    repeat (8) @(posedge CLK);
    #2;
    RST     = 1'b0;
    running = 1'b1;

    // Quiet bus and zeroed registers straight after reset
    repeat (N_SLICES) step(1'b0, 15'd0);
    for (int j = 0; j < 16; j++)
      repeat (N_SLICES) step(1'b1, enc_2r(4'h8, 4'(j), 4'(j)));

    // Per-slice values keep the slices apart
    for (int j = 0; j < 16; j++)
      repeat (N_SLICES) step(1'b1, enc_ldi(4'(j), 9'(turn * 97 + j * 41 + 3)));
    for (int j = 0; j < 16; j++)
      repeat (N_SLICES) step(1'b1, enc_addi(4'(j), 8'(j * 23 - turn * 11)));
    for (int j = 0; j < 16; j++)
      repeat (N_SLICES) step(1'b1, enc_2r(4'h8, 4'(j), 4'(j)));

    for (int i = 0; i < N_RANDOM; i++)
      step(1'b1, random_op());

    for (int i = 0; i < N_FIXED; i++)
      repeat (N_SLICES) step(1'b1, fixed_op(i));

    // Drain the pipe and see the last flags at each slice's turn
    repeat (N_SLICES + 4) step(1'b0, 15'd0);
    running = 1'b0;

    if (exp_q.size() != 0)
      $display("Results never appeared for %0d issued ops", exp_q.size());
    $display("Checks: %0d, errors: %0d, missing results: %0d", checks, errors, exp_q.size());
    if ((errors == 0) && (exp_q.size() == 0))
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

/* dv/au_cluster_assertions.sv */
// AU cluster assertions
// Writeback timing, slice tagging and result bus state after reset
`timescale 1ns/1ps

module au_cluster_assertions (
  input logic        CLK,
  input logic        RST,
  input logic        op_vld,
  input logic [14:0] op,
  input logic [2:0]  slice,
  input logic        rc_vld,
  input logic [2:0]  rc_slice
);

  logic flag_only;

  // Compare, test and compare-immediate only update the flags
  assign flag_only = (op[14:13] == 2'b10) ||
                     ((op[14:12] == 3'b010) && (op[11:9] == 3'd2)) ||
                     ((op[14:12] == 3'b000) && (op[11:8] == 4'hB));

  property wb_two_cycles_later;
    @(posedge CLK) disable iff (RST)
      $past(op_vld && !flag_only, 2) |-> rc_vld && (rc_slice == $past(slice, 2));
  endproperty

  property no_wb_for_flag_only;
    @(posedge CLK) disable iff (RST)
      $past(op_vld && flag_only, 2) |-> !rc_vld;
  endproperty

  property quiet_after_reset;
    @(posedge CLK) $fell(RST) |=> !rc_vld;
  endproperty

  assert property (wb_two_cycles_later)
    else $error("writeback missing two cycles after issue or tagged with the wrong slice");
  assert property (no_wb_for_flag_only)
    else $error("compare or test op produced a writeback");
  assert property (quiet_after_reset)
    else $error("rc_vld high in the cycle after reset release");

endmodule

bind au_cluster_top au_cluster_assertions au_cluster_assertions_inst (
  .CLK      (CLK),
  .RST      (RST),
  .op_vld   (op_vld),
  .op       (op),
  .slice    (slice),
  .rc_vld   (rc_vld),
  .rc_slice (rc_slice)
);

/* src/au_cluster_top.sv */
// AU cluster top level
// Barrel-threaded arithmetic cluster: shared decode and execute
// with one private register file per slice
`timescale 1ns/1ps

module au_cluster_top #(
  parameter int N_SLICES = 4
) (
  input  logic            CLK,
  input  logic            RST,
  input  logic            op_vld,
  input  au_pkg::au_op_t  op,
  output logic [2:0]      slice,
  output logic [7:0]      cur_flags,
  output logic            rc_vld,
  output logic [2:0]      rc_slice,
  output logic [3:0]      rc_sel,
  output logic [31:0]     rc
);

  import au_pkg::*;

  logic [2:0]  rd_slice;
  logic [3:0]  ra_sel;
  logic [3:0]  rb_sel;
  logic [31:0] ra_data;
  logic [31:0] rb_data;
  logic [31:0] ra_data_all [N_SLICES];
  logic [31:0] rb_data_all [N_SLICES];
  logic [7:0]  flags_all [N_SLICES];
  au_issue_t   issue;
  au_result_t  result;

  au_op_decode #(
    .N_SLICES (N_SLICES)
  ) au_op_decode_inst (
    .CLK     (CLK),
    .RST     (RST),
    .op_vld  (op_vld),
    .op      (op),
    .ra_data (ra_data),
    .rb_data (rb_data),
    .slice   (rd_slice),
    .ra_sel  (ra_sel),
    .rb_sel  (rb_sel),
    .issue   (issue)
  );

  for (genvar s = 0; s < N_SLICES; s++)
  begin : g_slice
    slice_regfile #(
      .SLICE_ID (s)
    ) slice_regfile_inst (
      .CLK     (CLK),
      .RST     (RST),
      .ra_sel  (ra_sel),
      .rb_sel  (rb_sel),
      .result  (result),
      .ra_data (ra_data_all[s]),
      .rb_data (rb_data_all[s]),
      .flags   (flags_all[s])
    );
  end

  // Read data and flags of the slice whose turn it is
  always_comb
  begin
    ra_data   = '0;
    rb_data   = '0;
    cur_flags = '0;
    for (int i = 0; i < N_SLICES; i++)
    begin
      if (rd_slice == 3'(i))
      begin
        ra_data   = ra_data_all[i];
        rb_data   = rb_data_all[i];
        cur_flags = flags_all[i];
      end
    end
  end

  au_execute au_execute_inst (
    .CLK    (CLK),
    .RST    (RST),
    .issue  (issue),
    .result (result)
  );

  assign slice    = rd_slice;
  assign rc_vld   = result.valid && result.wb;
  assign rc_slice = result.slice;
  assign rc_sel   = result.rc_sel;
  assign rc       = result.data;

endmodule

/* src/au_execute.sv */
// AU execute stage
// Two-register, bit and immediate operations on a 33-bit datapath
// with a sign guard bit, flag generation and the registered result
`timescale 1ns/1ps

module au_execute (
  input  logic                CLK,
  input  logic                RST,
  input  au_pkg::au_issue_t   issue,
  output au_pkg::au_result_t  result
);

  import au_pkg::*;

  logic [32:0] sx_a;
  logic [32:0] sx_b;
  logic [4:0]  bsel;
  logic [31:0] bmask;
  logic [32:0] low_mask;
  logic [32:0] tworeg_res;
  logic [32:0] bitop_res;
  logic [32:0] imm_res;
  logic [32:0] res;
  logic [7:0]  flags;

  assign sx_a  = {issue.a[31], issue.a};
  assign sx_b  = {issue.b[31], issue.b};
  assign bsel  = issue.b[4:0];
  assign bmask = 32'd1 << bsel;

  // Bits below the select survive a sign extend
  assign low_mask = (33'd1 << bsel) - 33'd1;

  always_comb
  begin
    case (issue.cmd)
      TR_OR:   tworeg_res = {1'b0, issue.a | issue.b};
      TR_AND:  tworeg_res = {1'b0, issue.a & issue.b};
      TR_XOR:  tworeg_res = {1'b0, issue.a ^ issue.b};
      TR_ADD:  tworeg_res = sx_a + sx_b;
      TR_SUB:  tworeg_res = sx_a - sx_b;
      TR_MOV:  tworeg_res = sx_b;
      TR_NOT:  tworeg_res = ~sx_b;
      TR_NEG:  tworeg_res = 33'd0 - sx_b;
      TR_CMP:  tworeg_res = sx_a - sx_b;
      default: tworeg_res = '0;
    endcase
  end

  always_comb
  begin
    case (issue.cmd[2:0])
      BO_SET:  bitop_res = {1'b0, issue.a | bmask};
      BO_CLR:  bitop_res = {1'b0, issue.a & ~bmask};
      BO_TST:  bitop_res = {1'b0, issue.a & bmask};
      // Bit shifted out of bit 31 lands in the guard
      BO_SHL:  bitop_res = {1'b0, issue.a} << bsel;
      BO_SHR:  bitop_res = {1'b0, issue.a} >> bsel;
      BO_ASR:  bitop_res = $signed(sx_a) >>> bsel;
      BO_SEXT: bitop_res = (sx_a & low_mask) | ({33{issue.a[bsel]}} & ~low_mask);
      default: bitop_res = '0;
    endcase
  end

  // Immediate already sign extended into operand b
  always_comb
  begin
    case (issue.cmd[1:0])
      IM_ADD:  imm_res = sx_a + sx_b;
      IM_CMP:  imm_res = sx_a - sx_b;
      IM_LD:   imm_res = sx_b;
      default: imm_res = '0;
    endcase
  end

  always_comb
  begin
    case (issue.cls)
      CL_TWOREG: res = tworeg_res;
      CL_BITOP:  res = bitop_res;
      CL_IMM:    res = imm_res;
      default:   res = '0;
    endcase
  end

  always_comb
  begin
    flags         = '0;
    flags[FLAG_Z] = (res[31:0] == 32'd0);
    flags[FLAG_N] = res[31];
    // Guard and sign disagree on signed overflow
    flags[FLAG_V] = res[32] ^ res[31];
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      result <= '0;
    else
    begin
      result.valid <= issue.valid;
      result.wb    <= issue.valid && issue.wb;
      if (issue.valid)
      begin
        result.slice  <= issue.slice;
        result.rc_sel <= issue.rc_sel;
        result.data   <= res[31:0];
        result.flags  <= flags;
      end
    end
  end

endmodule

/* src/slice_regfile.sv */
// Slice register file
// Sixteen 32-bit registers and a flag word private to one slice,
// two combinational read ports and one tagged write port
`timescale 1ns/1ps

module slice_regfile #(
  parameter int SLICE_ID = 0
) (
  input  logic                CLK,
  input  logic                RST,
  input  logic [3:0]          ra_sel,
  input  logic [3:0]          rb_sel,
  input  au_pkg::au_result_t  result,
  output logic [31:0]         ra_data,
  output logic [31:0]         rb_data,
  output logic [7:0]          flags
);

  logic [31:0] regs [16];
  logic [7:0]  flags_q;
  logic        hit;

  // Only results tagged for this slice land here
  assign hit = result.valid && (result.slice == 3'(SLICE_ID));

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      for (int i = 0; i < 16; i++)
        regs[i] <= '0;
      flags_q <= '0;
    end
    else if (hit)
    begin
      if (result.wb)
        regs[result.rc_sel] <= result.data;
      // Flags follow every op, compares included
      flags_q <= result.flags;
    end
  end

  assign ra_data = regs[ra_sel];
  assign rb_data = regs[rb_sel];
  assign flags   = flags_q;

endmodule

/* src/au_op_decode.sv */
// AU op decode
// Rotates the slice counter, decodes the instruction word into class,
// command and register selects, builds operand b and registers the issue
`timescale 1ns/1ps

module au_op_decode #(
  parameter int N_SLICES = 4
) (
  input  logic                CLK,
  input  logic                RST,
  input  logic                op_vld,
  input  au_pkg::au_op_t      op,
  input  logic [31:0]         ra_data,
  input  logic [31:0]         rb_data,
  output logic [2:0]          slice,
  output logic [3:0]          ra_sel,
  output logic [3:0]          rb_sel,
  output au_pkg::au_issue_t   issue
);

  import au_pkg::*;

  logic [2:0]  slice_q;
  logic [2:0]  cls;
  logic        is_tworeg;
  logic        is_3r;
  logic        is_bitop;
  logic        is_imm;
  au_class_e   op_class;
  logic [3:0]  cmd;
  logic [3:0]  rc_sel;
  logic        wb;
  logic [31:0] imm_val;
  logic [31:0] opnd_b;

  assign slice = slice_q;

  // One slice per cycle, wraps at N_SLICES
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      slice_q <= '0;
    else if (slice_q == 3'(N_SLICES - 1))
      slice_q <= '0;
    else
      slice_q <= slice_q + 3'd1;
  end

  always_comb
  begin
    cls       = op.tworeg_2r.cls;
    is_tworeg = (cls[2:1] == 2'b00);
    is_3r     = is_tworeg && op.tworeg_3r.fmt3;
    is_bitop  = (cls == 3'b010);
    is_imm    = cls[2] || (cls == 3'b011);

    if (is_imm)
      op_class = CL_IMM;
    else if (is_bitop)
      op_class = CL_BITOP;
    else
      op_class = CL_TWOREG;

    // Three-register form only reaches the low eight registers
    ra_sel = is_3r ? {1'b0, op.tworeg_3r.ra} : op.tworeg_2r.ra;
    rb_sel = is_3r ? {1'b0, op.tworeg_3r.rb} : op.tworeg_2r.rb;
    rc_sel = is_3r ? {1'b0, op.tworeg_3r.rc} : op.tworeg_2r.ra;

    if (is_imm)
      cmd = {2'b00, op.imm.cls};
    else if (is_bitop)
      cmd = {1'b0, op.bitop.cmd};
    else if (is_3r)
      cmd = {1'b0, op.tworeg_3r.cmd};
    else
      cmd = op.tworeg_2r.cmd;

    // Compares and tests only touch the flags
    if (is_imm)
      wb = (cmd[1:0] != IM_CMP);
    else if (is_bitop)
      wb = (cmd[2:0] != BO_TST);
    else
      wb = (cmd != TR_CMP);

    // Load and compare use 9 bits, add uses 8
    if (op.imm.cls[1])
      imm_val = {{23{op.imm.val[8]}}, op.imm.val};
    else
      imm_val = {{24{op.imm.val[7]}}, op.imm.val[7:0]};

    if (is_imm)
      opnd_b = imm_val;
    else if (is_bitop)
      opnd_b = {27'd0, op.bitop.bsel};
    else
      opnd_b = rb_data;
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      issue <= '0;
    else
    begin
      issue.valid <= op_vld;
      if (op_vld)
      begin
        issue.cls    <= op_class;
        issue.cmd    <= cmd;
        issue.slice  <= slice_q;
        issue.rc_sel <= rc_sel;
        issue.wb     <= wb;
        issue.a      <= ra_data;
        issue.b      <= opnd_b;
      end
    end
  end

endmodule

/* src/au_pkg.sv */
// AU cluster shared definitions
// Instruction word views, op codes, flag positions and the bundles
// passed from decode to execute and from execute to the register files
package au_pkg;

  localparam int SLICE_W = 3;

  // Flag word bit positions, upper bits stay 0
  localparam int FLAG_Z = 0;
  localparam int FLAG_N = 1;
  localparam int FLAG_V = 2;

  typedef enum logic [1:0]
  {
    CL_TWOREG = 2'd0,
    CL_BITOP  = 2'd1,
    CL_IMM    = 2'd2
  } au_class_e;

  typedef enum logic [3:0]
  {
    TR_OR  = 4'h0,
    TR_AND = 4'h1,
    TR_XOR = 4'h2,
    TR_ADD = 4'h3,
    TR_SUB = 4'h4,
    TR_MOV = 4'h8,
    TR_NOT = 4'h9,
    TR_NEG = 4'hA,
    TR_CMP = 4'hB
  } tworeg_cmd_e;

  typedef enum logic [2:0]
  {
    BO_SET  = 3'd0,
    BO_CLR  = 3'd1,
    BO_TST  = 3'd2,
    BO_SHL  = 3'd4,
    BO_SHR  = 3'd5,
    BO_ASR  = 3'd6,
    BO_SEXT = 3'd7
  } bitop_cmd_e;

  // Immediate command is the class field op[14:13]
  typedef enum logic [1:0]
  {
    IM_ADD = 2'd1,
    IM_CMP = 2'd2,
    IM_LD  = 2'd3
  } imm_cmd_e;

  typedef struct packed {
    logic [2:0] cls;
    logic [3:0] cmd;
    logic [3:0] rb;
    logic [3:0] ra;
  } au_tworeg_2r_t;

  typedef struct packed {
    logic [1:0] cls;
    logic       fmt3;
    logic [2:0] cmd;
    logic [2:0] rc;
    logic [2:0] rb;
    logic [2:0] ra;
  } au_tworeg_3r_t;

  typedef struct packed {
    logic [2:0] cls;
    logic [2:0] cmd;
    logic [4:0] bsel;
    logic [3:0] rs;
  } au_bitop_t;

  // 9-bit value for load and compare, low 8 bits for add
  typedef struct packed {
    logic [1:0] cls;
    logic [8:0] val;
    logic [3:0] rs;
  } au_imm_t;

  typedef union packed {
    au_tworeg_2r_t tworeg_2r;
    au_tworeg_3r_t tworeg_3r;
    au_bitop_t     bitop;
    au_imm_t       imm;
  } au_op_t;

  typedef struct packed {
    logic               valid;
    au_class_e          cls;
    logic [3:0]         cmd;
    logic [SLICE_W-1:0] slice;
    logic [3:0]         rc_sel;
    logic               wb;
    logic [31:0]        a;
    logic [31:0]        b;
  } au_issue_t;

  typedef struct packed {
    logic               valid;
    logic               wb;
    logic [SLICE_W-1:0] slice;
    logic [3:0]         rc_sel;
    logic [31:0]        data;
    logic [7:0]         flags;
  } au_result_t;

endpackage
